// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // Word address width
    // 10 bits covers 1024 words
    localparam int unsigned MEM_ADDR_WIDTH = 10;

    // Width of one memory word
    localparam int unsigned MEM_DATA_WIDTH = 32;

    // One strobe bit per byte lane
    localparam int unsigned MEM_STRB_WIDTH = MEM_DATA_WIDTH / 8;

    // Request payload carried through the request cut chain
    // Field order sets the packed bit layout, addr sits in the MSBs
    typedef struct packed {
        // Word address
        logic [MEM_ADDR_WIDTH-1:0] addr;
        // Write data, ignored for reads
        logic [MEM_DATA_WIDTH-1:0] wdata;
        // Byte enables for writes
        logic [MEM_STRB_WIDTH-1:0] strb;
        // High for a write, low for a read
        logic                      write;
    } mem_req_payload_t;

    // Response payload carried through the response cut chain
    // Only reads produce a response, so it holds read data alone
    typedef struct packed {
        // Read data
        logic [MEM_DATA_WIDTH-1:0] rdata;
    } mem_rsp_payload_t;

endpackage

`default_nettype wire

// ==== mem_cut.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_cut #(
    // Payload carried by this stage
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Upstream side
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,

    // Downstream side
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    // Output register
    logic     out_valid_q;
    payload_t out_data_q;

    // Skid entry, only used while the output is stalled
    logic     skid_valid_q;
    payload_t skid_data_q;

    // Handshakes on both sides
    logic     in_fire;
    logic     out_fire;

    // Output register is free this cycle or drains this cycle
    logic     out_free;

    // Ready comes straight from a flop, breaking the backward path
    assign ready_o  = ~skid_valid_q;

    assign in_fire  = valid_i & ready_o;
    assign out_fire = out_valid_q & ready_i;
    assign out_free = ~out_valid_q | out_fire;

    // Control state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else begin
            if (out_free) begin
                // Skid entry has priority, it holds the older item
                if (skid_valid_q) begin
                    out_valid_q  <= 1'b1;
                    skid_valid_q <= 1'b0;
                end else begin
                    out_valid_q  <= in_fire;
                end
            end else if (in_fire) begin
                // Output stalled, park the new item in the skid entry
                skid_valid_q <= 1'b1;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (out_free) begin
            if (skid_valid_q) begin
                out_data_q <= skid_data_q;
            end else if (in_fire) begin
                out_data_q <= data_i;
            end
        end
        // Skid only loads while the output is stalled
        if (!out_free && in_fire) begin
            skid_data_q <= data_i;
        end
    end

    // Outputs come from the output register
    assign valid_o = out_valid_q;
    assign data_o  = out_data_q;

endmodule

`default_nettype wire

// ==== mem_multicut.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_multicut import mem_pkg::*; #(
    // Cuts on the request path, 0 is a bypass
    parameter int unsigned NUM_CUTS_REQ = 0,
    // Cuts on the response path, 0 is a bypass
    parameter int unsigned NUM_CUTS_RSP = 0
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // Requester side request
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [MEM_ADDR_WIDTH-1:0] req_addr_i,
    input  logic [MEM_DATA_WIDTH-1:0] req_wdata_i,
    input  logic [MEM_STRB_WIDTH-1:0] req_strb_i,
    input  logic                      req_write_i,

    // Memory side request
    output logic                      mem_req_valid_o,
    input  logic                      mem_req_ready_i,
    output logic [MEM_ADDR_WIDTH-1:0] mem_req_addr_o,
    output logic [MEM_DATA_WIDTH-1:0] mem_req_wdata_o,
    output logic [MEM_STRB_WIDTH-1:0] mem_req_strb_o,
    output logic                      mem_req_write_o,

    // Memory side response
    input  logic                      mem_rsp_valid_i,
    input  logic [MEM_DATA_WIDTH-1:0] mem_rsp_rdata_i,
    output logic                      mem_rsp_ready_o,

    // Requester side response
    output logic                      rsp_valid_o,
    output logic [MEM_DATA_WIDTH-1:0] rsp_rdata_o,
    input  logic                      rsp_ready_i
);

    // Request chain nodes
    // Node 0 faces the requester, the last node faces the memory
    logic             req_valid [NUM_CUTS_REQ+1];
    logic             req_ready [NUM_CUTS_REQ+1];
    mem_req_payload_t req_data  [NUM_CUTS_REQ+1];

    // Response chain nodes
    // Node 0 faces the memory, the last node faces the requester
    logic             rsp_valid [NUM_CUTS_RSP+1];
    logic             rsp_ready [NUM_CUTS_RSP+1];
    mem_rsp_payload_t rsp_data  [NUM_CUTS_RSP+1];

    // Pack the loose request fields at the chain entry
    assign req_valid[0]      = req_valid_i;
    assign req_data[0].addr  = req_addr_i;
    assign req_data[0].wdata = req_wdata_i;
    assign req_data[0].strb  = req_strb_i;
    assign req_data[0].write = req_write_i;
    assign req_ready_o       = req_ready[0];

    // Each cut sits between node i and node i+1
    // With zero cuts the loop is empty and the two ends are the same node
    for (genvar i = 0; i < NUM_CUTS_REQ; i++) begin : g_req_cut
        mem_cut #(
            .payload_t (mem_req_payload_t)
        ) u_req_cut (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .valid_i (req_valid[i]),
            .ready_o (req_ready[i]),
            .data_i  (req_data[i]),
            .valid_o (req_valid[i+1]),
            .ready_i (req_ready[i+1]),
            .data_o  (req_data[i+1])
        );
    end

    // Unpack at the memory side
    assign mem_req_valid_o          = req_valid[NUM_CUTS_REQ];
    assign mem_req_addr_o           = req_data[NUM_CUTS_REQ].addr;
    assign mem_req_wdata_o          = req_data[NUM_CUTS_REQ].wdata;
    assign mem_req_strb_o           = req_data[NUM_CUTS_REQ].strb;
    assign mem_req_write_o          = req_data[NUM_CUTS_REQ].write;
    assign req_ready[NUM_CUTS_REQ]  = mem_req_ready_i;

    // Memory response enters the response chain
    assign rsp_valid[0]      = mem_rsp_valid_i;
    assign rsp_data[0].rdata = mem_rsp_rdata_i;
    // Read ready toward the memory, as seen through all response cuts
    assign mem_rsp_ready_o   = rsp_ready[0];

    // Response cuts, same structure as the request side
    for (genvar i = 0; i < NUM_CUTS_RSP; i++) begin : g_rsp_cut
        mem_cut #(
            .payload_t (mem_rsp_payload_t)
        ) u_rsp_cut (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .valid_i (rsp_valid[i]),
            .ready_o (rsp_ready[i]),
            .data_i  (rsp_data[i]),
            .valid_o (rsp_valid[i+1]),
            .ready_i (rsp_ready[i+1]),
            .data_o  (rsp_data[i+1])
        );
    end

    // Response leaves toward the requester
    assign rsp_valid_o             = rsp_valid[NUM_CUTS_RSP];
    assign rsp_rdata_o             = rsp_data[NUM_CUTS_RSP].rdata;
    assign rsp_ready[NUM_CUTS_RSP] = rsp_ready_i;

endmodule

`default_nettype wire

// ==== mem_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_sram import mem_pkg::*; #(
    // Number of words, at most 2**MEM_ADDR_WIDTH
    parameter int unsigned MEM_DEPTH = 1024
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // Request port
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [MEM_ADDR_WIDTH-1:0] req_addr_i,
    input  logic [MEM_DATA_WIDTH-1:0] req_wdata_i,
    input  logic [MEM_STRB_WIDTH-1:0] req_strb_i,
    input  logic                      req_write_i,

    // Read response port
    output logic                      rsp_valid_o,
    output logic [MEM_DATA_WIDTH-1:0] rsp_rdata_o,
    input  logic                      rsp_ready_i
);

    // Word storage
    logic [MEM_DATA_WIDTH-1:0] mem_q [MEM_DEPTH];

    // Read response register
    logic                      rsp_valid_q;
    logic [MEM_DATA_WIDTH-1:0] rsp_rdata_q;

    // Request handshake and its two flavours
    logic                      req_fire;
    logic                      wr_fire;
    logic                      rd_fire;

    // Response taken this cycle
    logic                      rsp_fire;

    // Accept a request unless a response is stuck in the register
    // A response leaving this cycle frees the slot for a new read
    assign req_ready_o = ~rsp_valid_q | rsp_ready_i;

    assign req_fire = req_valid_i & req_ready_o;
    assign wr_fire  = req_fire & req_write_i;
    assign rd_fire  = req_fire & ~req_write_i;
    assign rsp_fire = rsp_valid_q & rsp_ready_i;

    // Byte-masked write at acceptance
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            for (int b = 0; b < MEM_STRB_WIDTH; b++) begin
                // Only lanes with a set strobe change
                if (req_strb_i[b]) begin
                    mem_q[req_addr_i][8*b +: 8] <= req_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read data lands in the response register one cycle after acceptance
    // Earlier writes are already in the array, so data is always current
    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            rsp_rdata_q <= mem_q[req_addr_i];
        end
    end

    // Response valid, held until the consumer takes it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (rd_fire) begin
            // New read replaces a response that drains this cycle
            rsp_valid_q <= 1'b1;
        end else if (rsp_fire) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // Outputs straight from the register, stable under back-pressure
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;

endmodule

`default_nettype wire

// ==== mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_pkg::*; #(
    // Register cuts between the requester and the SRAM
    parameter int unsigned NUM_CUTS_REQ = 1,
    // Register cuts between the SRAM and the requester
    parameter int unsigned NUM_CUTS_RSP = 1,
    // SRAM size in words
    parameter int unsigned MEM_DEPTH    = 1024
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // Request from the external requester
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [MEM_ADDR_WIDTH-1:0] req_addr_i,
    input  logic [MEM_DATA_WIDTH-1:0] req_wdata_i,
    input  logic [MEM_STRB_WIDTH-1:0] req_strb_i,
    input  logic                      req_write_i,

    // Read response back to the requester
    output logic                      rsp_valid_o,
    output logic [MEM_DATA_WIDTH-1:0] rsp_rdata_o,
    input  logic                      rsp_ready_i
);

    // Request after the cut chain
    logic                      mem_req_valid;
    logic                      mem_req_ready;
    logic [MEM_ADDR_WIDTH-1:0] mem_req_addr;
    logic [MEM_DATA_WIDTH-1:0] mem_req_wdata;
    logic [MEM_STRB_WIDTH-1:0] mem_req_strb;
    logic                      mem_req_write;

    // Response before the cut chain
    logic                      mem_rsp_valid;
    logic [MEM_DATA_WIDTH-1:0] mem_rsp_rdata;
    // Read ready fed back through the response cuts
    logic                      mem_rsp_ready;

    mem_multicut #(
        .NUM_CUTS_REQ (NUM_CUTS_REQ),
        .NUM_CUTS_RSP (NUM_CUTS_RSP)
    ) u_multicut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_strb_i      (req_strb_i),
        .req_write_i     (req_write_i),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_addr_o  (mem_req_addr),
        .mem_req_wdata_o (mem_req_wdata),
        .mem_req_strb_o  (mem_req_strb),
        .mem_req_write_o (mem_req_write),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_rdata_i (mem_rsp_rdata),
        .mem_rsp_ready_o (mem_rsp_ready),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_rdata_o     (rsp_rdata_o),
        .rsp_ready_i     (rsp_ready_i)
    );

    mem_sram #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_sram (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (mem_req_valid),
        .req_ready_o (mem_req_ready),
        .req_addr_i  (mem_req_addr),
        .req_wdata_i (mem_req_wdata),
        .req_strb_i  (mem_req_strb),
        .req_write_i (mem_req_write),
        .rsp_valid_o (mem_rsp_valid),
        .rsp_rdata_o (mem_rsp_rdata),
        .rsp_ready_i (mem_rsp_ready)
    );

endmodule

`default_nettype wire

// ==== tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    // DUT configuration with the request path bypassed and two response cuts
    localparam int unsigned NUM_CUTS_REQ   = 0;
    localparam int unsigned NUM_CUTS_RSP   = 2;
    localparam int unsigned MEM_DEPTH      = 1024;
    // Cycles from read acceptance to response valid
    localparam int unsigned RSP_LATENCY    = NUM_CUTS_REQ + 1 + NUM_CUTS_RSP;
    // Bound for every wait loop
    localparam int unsigned TIMEOUT_CYCLES = 200;
    localparam int unsigned RANDOM_CYCLES  = 400;

    logic                      clk_i;
    logic                      rst_n_i;
    logic                      req_valid_i;
    logic                      req_ready_o;
    logic [MEM_ADDR_WIDTH-1:0] req_addr_i;
    logic [MEM_DATA_WIDTH-1:0] req_wdata_i;
    logic [MEM_STRB_WIDTH-1:0] req_strb_i;
    logic                      req_write_i;
    logic                      rsp_valid_o;
    logic [MEM_DATA_WIDTH-1:0] rsp_rdata_o;
    logic                      rsp_ready_i;

    // Reference model state owned by the monitor
    logic [MEM_DATA_WIDTH-1:0] shadow [MEM_DEPTH];
    logic [MEM_DATA_WIDTH-1:0] exp_data_q [$];
    int unsigned               exp_cyc_q [$];
    // Registered views of the model for the assertions and the stimulus
    int unsigned               exp_cnt       = 0;
    logic [MEM_DATA_WIDTH-1:0] exp_head_data = '0;
    int unsigned               exp_head_cyc  = 0;
    int unsigned               cycle_cnt     = 0;
    logic                      hold_pend     = 1'b0;
    logic [MEM_DATA_WIDTH-1:0] hold_data     = '0;
    logic                      ready_dropped = 1'b0;
    logic                      lat_en        = 1'b0;

    int                        data_errs = 0;
    int                        proto_errs = 0;
    int                        tmo_errs = 0;
    string                     test_name = "reset";
    logic [15:0]               lfsr_q = 16'd53;

    mem_subsys_top #(
        .NUM_CUTS_REQ (NUM_CUTS_REQ),
        .NUM_CUTS_RSP (NUM_CUTS_RSP),
        .MEM_DEPTH    (MEM_DEPTH)
    ) DUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_strb_i  (req_strb_i),
        .req_write_i (req_write_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_ready_i (rsp_ready_i)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    // 16-bit Galois LFSR with taps at 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int unsigned n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // Monitor sees the values that held during the cycle ending at this edge
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            hold_pend <= 1'b0;
        end else begin
            if (req_valid_i && req_ready_o) begin
                if (req_write_i) begin
                    // Byte merge into the shadow word
                    for (int b = 0; b < MEM_STRB_WIDTH; b++) begin
                        if (req_strb_i[b]) begin
                            shadow[req_addr_i][8*b +: 8] = req_wdata_i[8*b +: 8];
                        end
                    end
                end else begin
                    exp_data_q.push_back(shadow[req_addr_i]);
                    exp_cyc_q.push_back(cycle_cnt);
                end
            end
            if (rsp_valid_o && rsp_ready_i && exp_data_q.size() != 0) begin
                void'(exp_data_q.pop_front());
                void'(exp_cyc_q.pop_front());
            end
            if (!req_ready_o) begin
                ready_dropped <= 1'b1;
            end
            // Response offered but not taken must hold next cycle
            hold_pend <= rsp_valid_o && !rsp_ready_i;
            hold_data <= rsp_rdata_o;
        end
        cycle_cnt <= cycle_cnt + 1;
        exp_cnt   <= exp_data_q.size();
        if (exp_data_q.size() != 0) begin
            exp_head_data <= exp_data_q[0];
            exp_head_cyc  <= exp_cyc_q[0];
        end
    end

    // No response while reset is asserted
    // The first edge is skipped while the cut flops are still unknown
    assert property (@(posedge clk_i) (cycle_cnt != 0 && !rst_n_i) |-> !rsp_valid_o)
    else begin
        proto_errs++;
        $display("rsp_valid_o was high while reset was asserted");
    end

    assert property (@(posedge clk_i) $rose(rst_n_i) |-> !rsp_valid_o && req_ready_o)
    else begin
        proto_errs++;
        $display("ERR reset expected valid 0 ready 1 actual valid %b ready %b",
                 $sampled(rsp_valid_o), $sampled(req_ready_o));
    end

    // Every taken response belongs to an outstanding read
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o && rsp_ready_i |-> exp_cnt != 0)
    else begin
        proto_errs++;
        $display("A response arrived with no read outstanding");
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o && rsp_ready_i && exp_cnt != 0 |-> rsp_rdata_o == exp_head_data)
    else begin
        data_errs++;
        $display("ERR %s expected %h actual %h", test_name,
                 $sampled(exp_head_data), $sampled(rsp_rdata_o));
    end

    // Isolated reads with the consumer always ready
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        lat_en && $rose(rsp_valid_o) |-> (cycle_cnt - exp_head_cyc) == RSP_LATENCY)
    else begin
        data_errs++;
        $display("ERR %s expected %0d actual %0d", test_name, RSP_LATENCY,
                 $sampled(cycle_cnt) - $sampled(exp_head_cyc));
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) hold_pend |-> rsp_valid_o)
    else begin
        proto_errs++;
        $display("rsp_valid_o dropped before the response was taken");
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hold_pend |-> rsp_rdata_o == hold_data)
    else begin
        data_errs++;
        $display("ERR %s expected %h actual %h", test_name,
                 $sampled(hold_data), $sampled(rsp_rdata_o));
    end

    // Called right after a rising edge and returns at the edge of the transfer
    task automatic send_req(input logic wr, input logic [MEM_ADDR_WIDTH-1:0] addr,
                            input logic [MEM_DATA_WIDTH-1:0] wdata,
                            input logic [MEM_STRB_WIDTH-1:0] strb);
        int unsigned waited;
        req_valid_i <= 1'b1;
        req_write_i <= wr;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        req_strb_i  <= strb;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
        end while (!req_ready_o && waited < TIMEOUT_CYCLES);
        if (!req_ready_o) begin
            tmo_errs++;
            $display("Timeout: request to address %h was never accepted", addr);
        end
        req_valid_i <= 1'b0;
    endtask

    // Wait until every outstanding read has returned
    task automatic wait_drain();
        int unsigned waited;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
        end while (exp_cnt != 0 && waited < TIMEOUT_CYCLES);
        if (exp_cnt != 0) begin
            tmo_errs++;
            $display("Timeout: %0d read responses never arrived", exp_cnt);
        end
    endtask

    // Random requests and random consumer ready with one iteration per cycle
    task automatic run_random(input int unsigned n_cycles);
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] a;
        logic [31:0] s;
        logic        pending;
        int unsigned stall;
        pending = 1'b0;
        stall = 0;
        for (int c = 0; c < n_cycles; c++) begin
            if (pending && req_ready_o) begin
                pending = 1'b0;
                stall = 0;
                req_valid_i <= 1'b0;
            end else if (pending) begin
                stall++;
                if (stall == TIMEOUT_CYCLES) begin
                    tmo_errs++;
                    $display("Timeout: random request stalled too long");
                end
            end
            if (!pending) begin
                take_bits(2, r);
                // Three in four cycles carry a new request
                if (r[1:0] != 2'b00) begin
                    take_bits(1, r);
                    take_bits(4, a);
                    take_bits(32, d);
                    take_bits(4, s);
                    req_valid_i <= 1'b1;
                    req_write_i <= r[0];
                    req_addr_i  <= a[MEM_ADDR_WIDTH-1:0];
                    req_wdata_i <= d;
                    req_strb_i  <= s[MEM_STRB_WIDTH-1:0];
                    pending = 1'b1;
                end
            end
            take_bits(1, r);
            rsp_ready_i <= r[0];
            @(posedge clk_i);
        end
        // Finish the last request with the consumer ready
        rsp_ready_i <= 1'b1;
        stall = 0;
        while (pending && stall < TIMEOUT_CYCLES) begin
            if (req_ready_o) begin
                pending = 1'b0;
            end else begin
                @(posedge clk_i);
                stall++;
            end
        end
        if (pending) begin
            tmo_errs++;
            $display("Timeout: last random request was never accepted");
        end
        req_valid_i <= 1'b0;
    endtask

    initial begin
        logic [31:0] d;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_strb_i  = '0;
        req_write_i = 1'b0;
        rsp_ready_i = 1'b1;
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        lat_en  <= 1'b1;

        // Words 0 to 15 back the random reads
        test_name = "init";
        for (int i = 0; i < 16; i++) begin
            take_bits(32, d);
            send_req(1'b1, MEM_ADDR_WIDTH'(i), d, 4'hF);
        end

        test_name = "write_read";
        take_bits(32, d);
        send_req(1'b1, 10'h155, d, 4'hF);
        send_req(1'b0, 10'h155, '0, '0);
        wait_drain();

        test_name = "byte_strobe";
        take_bits(32, d);
        send_req(1'b1, 10'h2AA, d, 4'hF);
        take_bits(32, d);
        send_req(1'b1, 10'h2AA, d, 4'b0101);
        send_req(1'b0, 10'h2AA, '0, '0);
        wait_drain();
        take_bits(32, d);
        send_req(1'b1, 10'h2AA, d, 4'b1000);
        send_req(1'b0, 10'h2AA, '0, '0);
        wait_drain();

        test_name = "latency";
        for (int i = 0; i < 4; i++) begin
            send_req(1'b0, MEM_ADDR_WIDTH'(i), '0, '0);
            wait_drain();
        end

        test_name = "backpressure";
        lat_en <= 1'b0;
        run_random(RANDOM_CYCLES);

        test_name = "drain";
        wait_drain();
        // Quiet cycles expose duplicated responses
        repeat (10) @(posedge clk_i);

        assert (exp_cnt == 0) else begin
            proto_errs++;
            $display("ERR drain expected 0 actual %0d", exp_cnt);
        end
        assert (ready_dropped) else begin
            proto_errs++;
            $display("req_ready_o never dropped during the random phase");
        end

        $display("Error counts: data %0d, protocol %0d, timeout %0d",
                 data_errs, proto_errs, tmo_errs);
        if (data_errs == 0 && proto_errs == 0 && tmo_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
mem_pkg.sv
mem_cut.sv
mem_multicut.sv
mem_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv
